/* decd_isa_pkg.sv */
// ----------------------------------------------------------------------
// Instruction encoding for the pipe-1 decoder.
// Holds the word width, immediate field positions and the major
// opcodes that pick the source-1 immediate class.
// Imported by the immediate generator; ports use scoped names.
// ----------------------------------------------------------------------
package decd_isa_pkg;

    localparam int INST_W      = 32;
    localparam int SHIFT_IMM_W = 6;     // shift / pick immediate

    // ------------------------------------------------------------------
    // field positions
    // ------------------------------------------------------------------
    localparam int MAJOR_MSB     = 31;
    localparam int MAJOR_LSB     = 25;  // 7-bit major opcode
    localparam int IMM12_MSB     = 21;
    localparam int IMM16_MSB     = 25;
    localparam int IMM_LSB       = 10;  // imm12 and imm16 share the lsb
    localparam int IMM20_MSB     = 24;
    localparam int IMM20_LSB     = 5;
    localparam int SHIFT_SEL_BIT = 13;  // picks offset form of shift_imm

    // major opcodes in bits 31..25
    typedef enum logic [6:0] {
        IMM12_GRP = 7'b0000001,         // slti .. xori
        LU12I     = 7'b0001010,
        LU32I     = 7'b0001011,
        PCADDI    = 7'b0001100,
        PCALAU12I = 7'b0001101,
        PCADDU12I = 7'b0001110,
        PCADDU18I = 7'b0001111
    } imm_major_e;

    // addu16i.d is only 6 bits wide, bits 31..26
    localparam logic [5:0] ADDU16I_MAJOR = 6'b000100;

endpackage

/* decd_ctrl_pkg.sv */
// ----------------------------------------------------------------------
// Decoded control encodings for the pipe-1 decoder.
// Execution unit, ALU datapath select, one-hot opcode index and the
// function subcode. The decode table imports it, ports use scoped names.
// ----------------------------------------------------------------------
package decd_ctrl_pkg;

    typedef enum logic [1:0] {
        EU_NONE = 2'b00,
        EU_ALU  = 2'b01,
        EU_MULT = 2'b10
    } eu_sel_e;

    // ------------------------------------------------------------------
    // datapath select, codes as the ALU expects them
    // ------------------------------------------------------------------
    typedef enum logic [20:0] {
        NON_ALU        = 21'h000000,
        ADDER_ADD      = 21'h000001,
        ADDER_SUB      = 21'h000004,
        LOGIC_AND      = 21'h000400,
        LOGIC_OR       = 21'h000800,
        MISC_BPICK     = 21'h008001,
        MISC_SLT       = 21'h008002,
        MISC_MASK      = 21'h008004,
        MISC_RESERVERD = 21'h008080    // ALU decodes further from opcode
    } alu_sel_e;

    // bit index into the one-hot opcode vector
    localparam int ALU_OPCODE_NUM = 64;

    typedef enum logic [5:0] {
        OP_ALSL    = 6'd0,
        OP_BYTEPICK,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_MASKEQZ,
        OP_MASKNEZ,
        OP_NOR,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ORN,
        OP_ANDN,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ROTR,
        OP_SLLI    = 6'd27,             // gap left by dropped bit ops
        OP_SRLI,
        OP_SRAI,
        OP_ROTRI,
        OP_SLTI    = 6'd33,
        OP_SLTUI,
        OP_ADDI,
        OP_LU52I,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_ADDU16I,
        OP_LU12I,
        OP_LU32I,
        OP_MULT    = 6'd56
    } alu_opcode_e;

    // ------------------------------------------------------------------
    // function subcode
    // ------------------------------------------------------------------
    typedef enum logic [4:0] {
        SEL_W  = 5'd0,
        SEL_WU = 5'd1,
        SEL_D  = 5'd2
    } subcode_e;

    // multiplier reuses the same field, numbered 1 to 8
    localparam subcode_e MUL_W     = subcode_e'(5'd1);
    localparam subcode_e MULH_W    = subcode_e'(5'd2);
    localparam subcode_e MULH_WU   = subcode_e'(5'd3);
    localparam subcode_e MUL_D     = subcode_e'(5'd4);
    localparam subcode_e MULH_D    = subcode_e'(5'd5);
    localparam subcode_e MULH_DU   = subcode_e'(5'd6);
    localparam subcode_e MULW_D_W  = subcode_e'(5'd7);
    localparam subcode_e MULW_D_WU = subcode_e'(5'd8);

endpackage

/* decd_req_ack_ctrl.sv */
// ----------------------------------------------------------------------
// Four-phase req/ack front end of the decoder.
// Captures the instruction word on a sampled req and holds it, with ack
// high, until the requester drops req.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module decd_req_ack_ctrl (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            req,
    input  logic [decd_isa_pkg::INST_W-1:0] inst,
    output logic                            ack,
    output logic [decd_isa_pkg::INST_W-1:0] inst_q
);

    typedef enum logic {
        IDLE,
        HOLD
    } state_e;

    state_e state;
    state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_nxt = HOLD;       // word captured this edge
                end
            end
            HOLD: begin
                if (!req) begin
                    state_nxt = IDLE;       // requester released
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            inst_q <= '0;                   // shows invalid decode
        end else begin
            state <= state_nxt;
            if (state == IDLE && req) begin
                inst_q <= inst;             // frozen while in HOLD
            end
        end
    end

    assign ack = (state == HOLD);

endmodule

/* decd_inst_table.sv */
// ----------------------------------------------------------------------
// 32-bit decode table for pipe 1.
// Purely combinational from the captured word. Each kept encoding gives
// the unit, subcode, datapath select and one opcode bit; all else is
// the invalid decode.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module decd_inst_table (
    input  logic [decd_isa_pkg::INST_W-1:0]          inst_q,
    output decd_ctrl_pkg::eu_sel_e                   eu_sel,
    output decd_ctrl_pkg::subcode_e                  func,
    output decd_ctrl_pkg::alu_sel_e                  sel,
    output logic [decd_ctrl_pkg::ALU_OPCODE_NUM-1:0] inst_sel
);

    import decd_ctrl_pkg::*;

    localparam int EU_BITS   = $bits(eu_sel_e);
    localparam int FN_BITS   = $bits(subcode_e);
    localparam int ASEL_BITS = $bits(alu_sel_e);
    localparam int OP_BITS   = $bits(alu_opcode_e);
    localparam int DEC_W     = EU_BITS + FN_BITS + ASEL_BITS + OP_BITS;

    logic [DEC_W-1:0] dec;                  // packed table row

    function automatic logic [DEC_W-1:0] entry(eu_sel_e eu, subcode_e fn,
                                               alu_sel_e s, alu_opcode_e op);
        return {eu, fn, s, op};
    endfunction

    always_comb begin
        casez (inst_q[31:10])
            // ----------------------------------------------------------
            // register-register
            // ----------------------------------------------------------
            22'b000000000000010??_?????: dec = entry(EU_ALU, SEL_W,  ADDER_ADD, OP_ALSL);
            22'b000000000000011??_?????: dec = entry(EU_ALU, SEL_WU, ADDER_ADD, OP_ALSL);
            22'b000000000010110??_?????: dec = entry(EU_ALU, SEL_D,  ADDER_ADD, OP_ALSL);
            22'b000000000000100??_?????: dec = entry(EU_ALU, SEL_W,  MISC_BPICK, OP_BYTEPICK);
            22'b00000000000011???_?????: dec = entry(EU_ALU, SEL_D,  MISC_BPICK, OP_BYTEPICK);
            22'b00000000000100000_?????: dec = entry(EU_ALU, SEL_W,  ADDER_ADD, OP_ADD);
            22'b00000000000100001_?????: dec = entry(EU_ALU, SEL_D,  ADDER_ADD, OP_ADD);
            22'b00000000000100010_?????: dec = entry(EU_ALU, SEL_W,  ADDER_SUB, OP_SUB);
            22'b00000000000100011_?????: dec = entry(EU_ALU, SEL_D,  ADDER_SUB, OP_SUB);
            22'b00000000000100100_?????: dec = entry(EU_ALU, SEL_D,  MISC_SLT, OP_SLT);
            22'b00000000000100101_?????: dec = entry(EU_ALU, SEL_D,  MISC_SLT, OP_SLTU);
            22'b00000000000100110_?????: dec = entry(EU_ALU, SEL_D,  MISC_MASK, OP_MASKEQZ);
            22'b00000000000100111_?????: dec = entry(EU_ALU, SEL_D,  MISC_MASK, OP_MASKNEZ);
            22'b00000000000101000_?????: dec = entry(EU_ALU, SEL_D,  LOGIC_OR, OP_NOR);
            22'b00000000000101001_?????: dec = entry(EU_ALU, SEL_D,  LOGIC_AND, OP_AND);
            22'b00000000000101010_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_OR);
            22'b00000000000101011_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_XOR);
            22'b00000000000101100_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_ORN);
            22'b00000000000101101_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_ANDN);
            22'b00000000000101110_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_SLL);
            22'b00000000000101111_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_SRL);
            22'b00000000000110000_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_SRA);
            22'b00000000000110001_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_SLL);
            22'b00000000000110010_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_SRL);
            22'b00000000000110011_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_SRA);
            22'b00000000000110110_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_ROTR);
            22'b00000000000110111_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_ROTR);

            // shift and rotate by immediate, .d takes a 6-bit amount
            22'b00000000010000001_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_SLLI);
            22'b0000000001000001?_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_SLLI);
            22'b00000000010001001_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_SRLI);
            22'b0000000001000101?_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_SRLI);
            22'b00000000010010001_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_SRAI);
            22'b0000000001001001?_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_SRAI);
            22'b00000000010011001_?????: dec = entry(EU_ALU, SEL_W,  MISC_RESERVERD, OP_ROTRI);
            22'b0000000001001101?_?????: dec = entry(EU_ALU, SEL_D,  MISC_RESERVERD, OP_ROTRI);

            // ----------------------------------------------------------
            // 12-bit immediate group and upper-immediate forms
            // ----------------------------------------------------------
            22'b0000001000_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_SLTI);
            22'b0000001001_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_SLTUI);
            22'b0000001010_???????_?????: dec = entry(EU_ALU, SEL_W, MISC_RESERVERD, OP_ADDI);
            22'b0000001011_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_ADDI);
            22'b0000001100_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_LU52I);
            22'b0000001101_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_ANDI);
            22'b0000001110_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_ORI);
            22'b0000001111_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_XORI);
            22'b000100_????_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_ADDU16I);
            22'b0001010_???_???????_?????: dec = entry(EU_ALU, SEL_W, MISC_RESERVERD, OP_LU12I);
            22'b0001011_???_???????_?????: dec = entry(EU_ALU, SEL_D, MISC_RESERVERD, OP_LU32I);

            // ----------------------------------------------------------
            // multiplier
            // ----------------------------------------------------------
            22'b00000000000111000_?????: dec = entry(EU_MULT, MUL_W, MISC_RESERVERD, OP_MULT);
            22'b00000000000111001_?????: dec = entry(EU_MULT, MULH_W, MISC_RESERVERD, OP_MULT);
            22'b00000000000111010_?????: dec = entry(EU_MULT, MULH_WU, MISC_RESERVERD, OP_MULT);
            22'b00000000000111011_?????: dec = entry(EU_MULT, MUL_D, MISC_RESERVERD, OP_MULT);
            22'b00000000000111100_?????: dec = entry(EU_MULT, MULH_D, MISC_RESERVERD, OP_MULT);
            22'b00000000000111101_?????: dec = entry(EU_MULT, MULH_DU, MISC_RESERVERD, OP_MULT);
            22'b00000000000111110_?????: dec = entry(EU_MULT, MULW_D_W, MISC_RESERVERD, OP_MULT);
            22'b00000000000111111_?????: dec = entry(EU_MULT, MULW_D_WU, MISC_RESERVERD, OP_MULT);

            default: dec = '0;              // EU_NONE, SEL_W, NON_ALU
        endcase

        eu_sel = eu_sel_e'(dec[DEC_W-1 -: EU_BITS]);
        func   = subcode_e'(dec[OP_BITS+ASEL_BITS +: FN_BITS]);
        sel    = alu_sel_e'(dec[OP_BITS +: ASEL_BITS]);

        inst_sel = '0;
        if (eu_sel != EU_NONE) begin
            inst_sel[dec[OP_BITS-1:0]] = 1'b1;  // empty vector when invalid
        end
    end

endmodule

/* decd_imm_gen.sv */
// ----------------------------------------------------------------------
// Immediate generator for pipe 1.
// Classifies the major opcode as imm12, imm16 or imm20 and zero-extends
// that field into src1_imm. Also forms the 6-bit shift / pick immediate.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module decd_imm_gen #(
    parameter int IMM_W = 64            // 20 or wider
) (
    input  logic [decd_isa_pkg::INST_W-1:0]      inst_q,
    output logic [IMM_W-1:0]                     src1_imm,
    output logic [decd_isa_pkg::SHIFT_IMM_W-1:0] shift_imm
);

    import decd_isa_pkg::*;

    imm_major_e             major;
    logic                   is_imm12;
    logic                   is_imm16;
    logic                   is_imm20;
    logic [SHIFT_IMM_W-1:0] ext_offset;

    assign major = imm_major_e'(inst_q[MAJOR_MSB:MAJOR_LSB]);

    // ------------------------------------------------------------------
    // immediate class
    // ------------------------------------------------------------------
    assign is_imm12 = (major == IMM12_GRP);
    assign is_imm16 = (inst_q[MAJOR_MSB:MAJOR_LSB+1] == ADDU16I_MAJOR);
    assign is_imm20 = major inside {LU12I, LU32I, PCADDI, PCALAU12I,
                                    PCADDU12I, PCADDU18I};

    always_comb begin
        if (is_imm12) begin
            src1_imm = IMM_W'(inst_q[IMM12_MSB:IMM_LSB]);
        end else if (is_imm16) begin
            src1_imm = IMM_W'(inst_q[IMM16_MSB:IMM_LSB]);
        end else if (is_imm20) begin
            src1_imm = IMM_W'(inst_q[IMM20_MSB:IMM20_LSB]);
        end else begin
            src1_imm = '0;              // no immediate for this word
        end
    end

    // ------------------------------------------------------------------
    // shift / pick immediate
    // ------------------------------------------------------------------
    assign ext_offset = inst_q[31:26] - inst_q[25:20];   // wraps mod 64

    assign shift_imm = inst_q[SHIFT_SEL_BIT] ? ext_offset
                                             : SHIFT_IMM_W'(inst_q[26:25]);

endmodule

/* decd_pipe1_top.sv */
// ----------------------------------------------------------------------
// Pipe-1 instruction decoder, top level.
// A requester hands over one 32-bit word per four-phase req/ack cycle.
// Decoded unit, subcode, select, one-hot opcode and immediates stay
// valid while ack is high. IMM_W sets the source-1 immediate width.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module decd_pipe1_top #(
    parameter int IMM_W = 64
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     req,
    input  logic [decd_isa_pkg::INST_W-1:0]          inst,
    output logic                                     ack,
    output decd_ctrl_pkg::eu_sel_e                   eu_sel,
    output decd_ctrl_pkg::subcode_e                  func,
    output decd_ctrl_pkg::alu_sel_e                  sel,
    output logic [decd_ctrl_pkg::ALU_OPCODE_NUM-1:0] inst_sel,
    output logic [IMM_W-1:0]                         src1_imm,
    output logic [decd_isa_pkg::SHIFT_IMM_W-1:0]     shift_imm
);

    logic [decd_isa_pkg::INST_W-1:0] inst_q;    // captured word

    decd_req_ack_ctrl decd_req_ack_ctrl_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .inst   (inst),
        .ack    (ack),
        .inst_q (inst_q)
    );

    decd_inst_table decd_inst_table_i (
        .inst_q   (inst_q),
        .eu_sel   (eu_sel),
        .func     (func),
        .sel      (sel),
        .inst_sel (inst_sel)
    );

    decd_imm_gen #(
        .IMM_W (IMM_W)
    ) decd_imm_gen_i (
        .inst_q    (inst_q),
        .src1_imm  (src1_imm),
        .shift_imm (shift_imm)
    );

endmodule

/* tb_decd_ref.svh */
// ----------------------------------------------------------------------
// Reference model for the pipe-1 decoder testbench.
// Gives the expected decode row, source-1 immediate and shift immediate
// of a 32-bit word. Included in the testbench module body after the
// package imports, and takes IMM_W from the includer.
// ----------------------------------------------------------------------
`ifndef TB_DECD_REF_SVH
`define TB_DECD_REF_SVH

localparam alu_sel_e RSVD = MISC_RESERVERD;

// row layout {eu[34:33], func[32:28], sel[27:7], valid[6], opcode[5:0]}
function automatic logic [34:0] pack_row(input eu_sel_e eu, input subcode_e fn,
                                         input alu_sel_e sl, input alu_opcode_e op);
    return {eu, fn, sl, 1'b1, op};
endfunction

function automatic logic [34:0] expect_decode(input logic [31:0] w);
    int op17;
    int op10;
    op17 = int'(w[31:15]);
    op10 = int'(w[31:22]);

    // upper-immediate forms, by major opcode
    if (w[31:26] == ADDU16I_MAJOR) return pack_row(EU_ALU, SEL_D, RSVD, OP_ADDU16I);
    if (w[31:25] == LU12I) return pack_row(EU_ALU, SEL_W, RSVD, OP_LU12I);
    if (w[31:25] == LU32I) return pack_row(EU_ALU, SEL_D, RSVD, OP_LU32I);

    case (op10)                                 // 12-bit immediate group
        8:  return pack_row(EU_ALU, SEL_D, RSVD, OP_SLTI);
        9:  return pack_row(EU_ALU, SEL_D, RSVD, OP_SLTUI);
        10: return pack_row(EU_ALU, SEL_W, RSVD, OP_ADDI);
        11: return pack_row(EU_ALU, SEL_D, RSVD, OP_ADDI);
        12: return pack_row(EU_ALU, SEL_D, RSVD, OP_LU52I);
        13: return pack_row(EU_ALU, SEL_D, RSVD, OP_ANDI);
        14: return pack_row(EU_ALU, SEL_D, RSVD, OP_ORI);
        15: return pack_row(EU_ALU, SEL_D, RSVD, OP_XORI);
        default: ;
    endcase

    // multiplier, subcode counts up from 1
    if (op17 >= 56 && op17 <= 63) return pack_row(EU_MULT, subcode_e'(5'(op17 - 55)), RSVD, OP_MULT);

    case (op17)
        8, 9, 10, 11:   return pack_row(EU_ALU, SEL_W,  ADDER_ADD,  OP_ALSL);
        12, 13, 14, 15: return pack_row(EU_ALU, SEL_WU, ADDER_ADD,  OP_ALSL);
        88, 89, 90, 91: return pack_row(EU_ALU, SEL_D,  ADDER_ADD,  OP_ALSL);
        16, 17, 18, 19: return pack_row(EU_ALU, SEL_W,  MISC_BPICK, OP_BYTEPICK);
        24, 25, 26, 27, 28, 29, 30, 31:
                        return pack_row(EU_ALU, SEL_D,  MISC_BPICK, OP_BYTEPICK);
        32:  return pack_row(EU_ALU, SEL_W, ADDER_ADD, OP_ADD);
        33:  return pack_row(EU_ALU, SEL_D, ADDER_ADD, OP_ADD);
        34:  return pack_row(EU_ALU, SEL_W, ADDER_SUB, OP_SUB);
        35:  return pack_row(EU_ALU, SEL_D, ADDER_SUB, OP_SUB);
        36:  return pack_row(EU_ALU, SEL_D, MISC_SLT, OP_SLT);
        37:  return pack_row(EU_ALU, SEL_D, MISC_SLT, OP_SLTU);
        38:  return pack_row(EU_ALU, SEL_D, MISC_MASK, OP_MASKEQZ);
        39:  return pack_row(EU_ALU, SEL_D, MISC_MASK, OP_MASKNEZ);
        40:  return pack_row(EU_ALU, SEL_D, LOGIC_OR, OP_NOR);
        41:  return pack_row(EU_ALU, SEL_D, LOGIC_AND, OP_AND);
        42:  return pack_row(EU_ALU, SEL_D, RSVD, OP_OR);
        43:  return pack_row(EU_ALU, SEL_D, RSVD, OP_XOR);
        44:  return pack_row(EU_ALU, SEL_D, RSVD, OP_ORN);
        45:  return pack_row(EU_ALU, SEL_D, RSVD, OP_ANDN);
        46:  return pack_row(EU_ALU, SEL_W, RSVD, OP_SLL);
        47:  return pack_row(EU_ALU, SEL_W, RSVD, OP_SRL);
        48:  return pack_row(EU_ALU, SEL_W, RSVD, OP_SRA);
        49:  return pack_row(EU_ALU, SEL_D, RSVD, OP_SLL);
        50:  return pack_row(EU_ALU, SEL_D, RSVD, OP_SRL);
        51:  return pack_row(EU_ALU, SEL_D, RSVD, OP_SRA);
        54:  return pack_row(EU_ALU, SEL_W, RSVD, OP_ROTR);
        55:  return pack_row(EU_ALU, SEL_D, RSVD, OP_ROTR);
        129: return pack_row(EU_ALU, SEL_W, RSVD, OP_SLLI);
        130, 131: return pack_row(EU_ALU, SEL_D, RSVD, OP_SLLI);   // 6-bit amount
        137: return pack_row(EU_ALU, SEL_W, RSVD, OP_SRLI);
        138, 139: return pack_row(EU_ALU, SEL_D, RSVD, OP_SRLI);
        145: return pack_row(EU_ALU, SEL_W, RSVD, OP_SRAI);
        146, 147: return pack_row(EU_ALU, SEL_D, RSVD, OP_SRAI);
        153: return pack_row(EU_ALU, SEL_W, RSVD, OP_ROTRI);
        154, 155: return pack_row(EU_ALU, SEL_D, RSVD, OP_ROTRI);
        default: ;
    endcase
    return '0;                                  // invalid decode
endfunction

function automatic logic [IMM_W-1:0] src1_imm_of(input logic [31:0] w);
    logic [IMM_W-1:0] v;
    v = '0;
    if (w[31:25] == IMM12_GRP) v[11:0] = w[21:10];
    else if (w[31:26] == ADDU16I_MAJOR) v[15:0] = w[25:10];
    else if (w[31:25] >= 7'd10 && w[31:25] <= 7'd15) v[19:0] = w[24:5];   // lu12i .. pcaddu18i
    return v;
endfunction

function automatic logic [5:0] shift_imm_of(input logic [31:0] w);
    int diff;
    diff = (int'(w[31:26]) - int'(w[25:20]) + 64) % 64;
    if (w[13]) return 6'(diff);
    return {4'd0, w[26:25]};
endfunction

`endif

/* tb_decd_pipe1_top.sv */
// ----------------------------------------------------------------------
// Testbench for the pipe-1 decoder.
// Runs four-phase handshakes over every kept encoding, random immediate
// words, back-pressure and dropped encodings. A negedge process checks
// every output against the reference model while ack is high.
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_decd_pipe1_top;

    import decd_isa_pkg::*;
    import decd_ctrl_pkg::*;

    localparam int IMM_W       = 64;
    localparam int TIMEOUT_CYC = 20;

    logic                      clk;
    logic                      arst_n;
    logic                      req;
    logic [INST_W-1:0]         inst;
    logic                      ack;
    eu_sel_e                   eu_sel;
    subcode_e                  func;
    alu_sel_e                  sel;
    logic [ALU_OPCODE_NUM-1:0] inst_sel;
    logic [IMM_W-1:0]          src1_imm;
    logic [SHIFT_IMM_W-1:0]    shift_imm;

    logic [INST_W-1:0] exp_word;                // word the DUT should hold
    integer            seed = 32'h541a;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                test_errors = 0;
    int                test_checks = 0;

    `include "tb_decd_ref.svh"

    decd_pipe1_top #(
        .IMM_W (IMM_W)
    ) decd_pipe1_top_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .inst      (inst),
        .ack       (ack),
        .eu_sel    (eu_sel),
        .func      (func),
        .sel       (sel),
        .inst_sel  (inst_sel),
        .src1_imm  (src1_imm),
        .shift_imm (shift_imm)
    );

    always #20 clk = ~clk;

    // ------------------------------------------------------------------
    // checking
    // ------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_outputs(input logic [INST_W-1:0] w);
        logic [34:0] r;
        logic [63:0] onehot;
        r      = expect_decode(w);
        onehot = r[6] ? (64'd1 << r[5:0]) : 64'd0;
        check_value("eu_sel", 64'(eu_sel), 64'(r[34:33]));
        check_value("func", 64'(func), 64'(r[32:28]));
        check_value("sel", 64'(sel), 64'(r[27:7]));
        check_value("inst_sel", inst_sel, onehot);
        check_value("src1_imm", 64'(src1_imm), 64'(src1_imm_of(w)));
        check_value("shift_imm", 64'(shift_imm), 64'(shift_imm_of(w)));
    endtask

    always @(negedge clk) begin
        if (arst_n === 1'b1 && ack === 1'b1) begin
            check_outputs(exp_word);            // held word, even under back-pressure
        end
    end

    // ------------------------------------------------------------------
    // handshake driver
    // ------------------------------------------------------------------
    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (ack !== level && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        if (ack !== level) begin
            errors++;
            $display("ERROR at %0t ns: ack did not go to %0d within %0d cycles",
                     $time, level, TIMEOUT_CYC);
        end
    endtask

    task automatic handshake(input logic [INST_W-1:0] word, input int hold);
        int i;
        @(posedge clk);
        #2;
        exp_word = word;
        inst     = word;
        req      = 1'b1;
        wait_ack(1'b1);
        for (i = 0; i < hold; i++) begin
            @(posedge clk);
            #2;
            inst = $random(seed);               // must not reach inst_q
            @(negedge clk);
            check_value("ack", 64'(ack), 64'd1);
        end
        @(posedge clk);
        #2;
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    // fixed top bits, random don't-care bits below
    task automatic send_fixed(input int prefix, input int width);
        logic [INST_W-1:0] word;
        word = $random(seed);
        word = (word & (32'hffff_ffff >> width)) | (32'(prefix) << (32 - width));
        handshake(word, 0);
    endtask

    task automatic close_test(input string name);
        tests++;
        $display("test %s: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // ------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------
    initial begin
        int i;
        int hold;
        clk      = 1'b0;
        arst_n   = 1'b0;
        req      = 1'b0;
        inst     = '0;
        exp_word = '0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        @(negedge clk);
        check_value("ack", 64'(ack), 64'd0);
        check_outputs('0);                      // cleared word is invalid
        close_test("reset");

        send_fixed(2, 15);                      // alsl.w
        send_fixed(3, 15);                      // alsl.wu
        send_fixed(22, 15);                     // alsl.d
        send_fixed(4, 15);                      // bytepick.w
        send_fixed(3, 14);                      // bytepick.d
        for (i = 32; i <= 51; i++) send_fixed(i, 17);
        send_fixed(54, 17);
        send_fixed(55, 17);
        for (i = 0; i < 4; i++) begin
            send_fixed(129 + 8 * i, 17);        // slli.w .. rotri.w
            send_fixed(65 + 4 * i, 16);         // slli.d .. rotri.d
        end
        for (i = 8; i <= 15; i++) send_fixed(i, 10);
        send_fixed(4, 6);                       // addu16i.d
        send_fixed(10, 7);
        send_fixed(11, 7);
        close_test("alu_table");

        for (i = 56; i <= 63; i++) send_fixed(i, 17);
        close_test("mult");

        for (i = 0; i < 8; i++) begin
            send_fixed(1, 7);
            send_fixed(4, 6);
            send_fixed(10 + i % 6, 7);
            handshake($random(seed), 0);
            handshake($random(seed) | 32'h2000, 0);
            handshake($random(seed) & ~32'h2000, 0);
        end
        close_test("immediates");

        for (i = 0; i < 4; i++) begin
            hold = {$random(seed)} % 10 + 1;
            handshake($random(seed), hold);
            send_fixed(32 + i, 17);             // fresh request after release
        end
        close_test("back_pressure");

        handshake(32'h0024_0000 | ({$random(seed)} & 32'h7fff), 0);     // crc.w.b.w
        handshake(32'h0000_1000 | ({$random(seed)} & 32'h3ff), 0);      // clo.w
        handshake(32'h0000_5800 | ({$random(seed)} & 32'h3ff), 0);      // ext.w.h
        handshake(32'h00c0_0000 | ({$random(seed)} & 32'h3f_ffff), 0);  // bstrpick.d
        handshake(32'h0114_a400 | ({$random(seed)} & 32'h3ff), 0);      // movgr2fr.w
        close_test("dropped");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* decd_pipe1.f */
+incdir+.
decd_isa_pkg.sv
decd_ctrl_pkg.sv
decd_req_ack_ctrl.sv
decd_inst_table.sv
decd_imm_gen.sv
decd_pipe1_top.sv
tb_decd_pipe1_top.sv

/* Makefile */
# Verilator flow for the pipe-1 decoder
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_decd_pipe1_top
RTL_TOP   ?= decd_pipe1_top
FILELIST  ?= decd_pipe1.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
